// ==== design/kick_consts.svh ====
`ifndef KICK_CONSTS_SVH
`define KICK_CONSTS_SVH

// Address map, upper bits pick the region and bits 10:8 the sub-port
`define KICK_BASE_MASK     16'hf800   // Region compare on bits 15:11
`define KICK_PORT_MASK     16'hff00   // Sub-port compare adds bits 10:8

`define KICK_IOW_ADDR      16'h0000   // flip, irq enable
`define KICK_TI2_ADDR      16'h0300   // Generator 2 write strobe
`define KICK_TI1_ADDR      16'h0400   // Generator 1 write strobe
`define KICK_DIP_ADDR      16'h0500   // Bit 0 picks dipsw_a or dipsw_b
`define KICK_IN_BASE       16'h0700   // Bits 1:0 pick the cabinet port
`define KICK_TIDATA2_BASE  16'h0800
`define KICK_TIDATA1_BASE  16'h1000
`define KICK_COLOR_BASE    16'h1800
`define KICK_VSCR_BASE     16'h2000

// Sound levels
`define KICK_VOL_STEP      16         // Tone level per unit of loudness
`define KICK_MIX_GAIN      8'h40      // 4.4 fixed point, x4.0
`define KICK_PEAK_LEVEL    4096

`endif

// ==== design/kick_pkg.sv ====
package kick_pkg;

    // Chip-select regions of the CPU address map
    typedef enum logic [3:0] {
        region_none,
        region_iow,
        region_in,
        region_dip,
        region_tidata1,
        region_tidata2,
        region_ti1,
        region_ti2,
        region_color,
        region_vscr
    } kick_region_e;

    // Generator register select, bits 6:4 of a latch byte
    typedef enum logic [2:0] {
        reg_tone0 = 3'd0,
        reg_att0  = 3'd1,
        reg_tone1 = 3'd2,
        reg_att1  = 3'd3,
        reg_tone2 = 3'd4,
        reg_att2  = 3'd5,
        reg_noise = 3'd6,
        reg_att3  = 3'd7
    } psg_reg_e;

    typedef logic [7:0] kick_byte_t;

    // Sum of three tone levels, at most 3 x 15 x 16
    typedef logic [9:0] psg_level_t;

    typedef logic signed [15:0] snd_t;

endpackage

// ==== design/kick_bus.sv ====
`timescale 1ns/1ns
`include "kick_consts.svh"

module kick_bus (
    input  logic                clk,
    input  logic                rst,
    input  logic [15:0]         addr,
    input  logic                rnw,
    input  kick_pkg::kick_byte_t cpu_dout,
    input  logic                bus_cen,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [5:0]          joystick1,
    input  logic [5:0]          joystick2,
    input  logic                service,
    input  kick_pkg::kick_byte_t dipsw_a,
    input  kick_pkg::kick_byte_t dipsw_b,
    input  logic [3:0]          dipsw_c,
    input  logic                dip_pause,
    input  logic                gfx_irqn,
    output kick_pkg::kick_byte_t cpu_din,
    output logic                flip,
    output logic [2:0]          pal_sel,
    output kick_pkg::kick_byte_t vpos,
    output logic                irq_n,
    output kick_pkg::kick_byte_t ti1_data,
    output kick_pkg::kick_byte_t ti2_data,
    output logic                ti1_we,
    output logic                ti2_we
);

    kick_pkg::kick_region_e region;
    kick_pkg::kick_byte_t   cabinet;
    kick_pkg::kick_byte_t   rd_val;
    logic                   wr, rd;
    logic                   irq_en;
    logic                   irq_flag;
    logic                   gfx_irqn_l;   // Last sampled gfx_irqn
    logic                   irq_fall;

    assign wr = bus_cen & ~rnw;
    assign rd = bus_cen &  rnw;

    always_comb begin
        region = kick_pkg::region_none;     // ROM, RAM and video fall here
        if ((addr & `KICK_PORT_MASK) == `KICK_IOW_ADDR)          region = kick_pkg::region_iow;
        else if ((addr & `KICK_PORT_MASK) == `KICK_TI2_ADDR)     region = kick_pkg::region_ti2;
        else if ((addr & `KICK_PORT_MASK) == `KICK_TI1_ADDR)     region = kick_pkg::region_ti1;
        else if ((addr & `KICK_PORT_MASK) == `KICK_DIP_ADDR)     region = kick_pkg::region_dip;
        else if ((addr & `KICK_PORT_MASK) == `KICK_IN_BASE)      region = kick_pkg::region_in;
        else if ((addr & `KICK_BASE_MASK) == `KICK_TIDATA2_BASE) region = kick_pkg::region_tidata2;
        else if ((addr & `KICK_BASE_MASK) == `KICK_TIDATA1_BASE) region = kick_pkg::region_tidata1;
        else if ((addr & `KICK_BASE_MASK) == `KICK_COLOR_BASE)   region = kick_pkg::region_color;
        else if ((addr & `KICK_BASE_MASK) == `KICK_VSCR_BASE)    region = kick_pkg::region_vscr;
    end

    // Cabinet ports, inputs are already active low
    always_comb begin
        case (addr[1:0])
            2'd0: cabinet = {4'hf, dipsw_c};
            2'd1: cabinet = {2'b11, joystick2[5:4], joystick2[2], joystick2[3],
                             joystick2[0], joystick2[1]};
            2'd2: cabinet = {2'b11, joystick1[5:4], joystick1[2], joystick1[3],
                             joystick1[0], joystick1[1]};
            default: cabinet = {3'b111, start_button, service, coin_input};
        endcase
        case (region)
            kick_pkg::region_in:  rd_val = cabinet;
            kick_pkg::region_dip: rd_val = addr[0] ? dipsw_b : dipsw_a;
            default:              rd_val = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd) cpu_din <= rd_val;
        if (wr && region == kick_pkg::region_tidata1) ti1_data <= cpu_dout;
        if (wr && region == kick_pkg::region_tidata2) ti2_data <= cpu_dout;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            flip    <= 1'b0;
            irq_en  <= 1'b0;
            pal_sel <= 3'd0;
            vpos    <= 8'd0;
            ti1_we  <= 1'b0;
            ti2_we  <= 1'b0;
        end else begin
            if (wr && region == kick_pkg::region_iow) begin
                flip   <= cpu_dout[0];
                irq_en <= cpu_dout[2];
            end
            if (wr && region == kick_pkg::region_color) pal_sel <= cpu_dout[2:0];
            if (wr && region == kick_pkg::region_vscr)  vpos    <= cpu_dout;
            ti1_we <= wr && region == kick_pkg::region_ti1;   // One-cycle pulse
            ti2_we <= wr && region == kick_pkg::region_ti2;
        end
    end

    // Interrupt flip-flop on the falling edge of gfx_irqn
    assign irq_fall = gfx_irqn_l & ~gfx_irqn;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            gfx_irqn_l <= 1'b1;
            irq_flag   <= 1'b0;
        end else begin
            gfx_irqn_l <= gfx_irqn;
            if (!irq_en)
                irq_flag <= 1'b0;                 // Acknowledge by clearing enable
            else if (irq_fall && dip_pause)
                irq_flag <= 1'b1;
        end
    end

    assign irq_n = ~(irq_flag & irq_en & dip_pause);

endmodule

// ==== design/kick_psg.sv ====
`timescale 1ns/1ns
`include "kick_consts.svh"

module kick_psg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psg_cen,
    input  logic                 we,
    input  kick_pkg::kick_byte_t din,
    output kick_pkg::psg_level_t level
);

    logic [9:0]          period [3];
    logic [3:0]          att    [3];
    logic [9:0]          cnt    [3];
    logic [2:0]          tone;          // Square outputs of the three channels
    kick_pkg::psg_reg_e  last_reg;      // Target of a data byte
    kick_pkg::psg_reg_e  op;

    assign op = kick_pkg::psg_reg_e'(din[6:4]);

    // Register protocol
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_reg <= kick_pkg::reg_tone0;
            for (int i = 0; i < 3; i++) begin
                period[i] <= 10'd0;
                att[i]    <= 4'hf;       // Silent
            end
        end else if (we) begin
            if (din[7]) begin
                last_reg <= op;
                case (op)
                    kick_pkg::reg_tone0: period[0][3:0] <= din[3:0];
                    kick_pkg::reg_tone1: period[1][3:0] <= din[3:0];
                    kick_pkg::reg_tone2: period[2][3:0] <= din[3:0];
                    kick_pkg::reg_att0:  att[0] <= din[3:0];
                    kick_pkg::reg_att1:  att[1] <= din[3:0];
                    kick_pkg::reg_att2:  att[2] <= din[3:0];
                    default: ;                  // No noise channel
                endcase
            end else begin
                // Upper period bits of the last tone selected
                case (last_reg)
                    kick_pkg::reg_tone0: period[0][9:4] <= din[5:0];
                    kick_pkg::reg_tone1: period[1][9:4] <= din[5:0];
                    kick_pkg::reg_tone2: period[2][9:4] <= din[5:0];
                    default: ;
                endcase
            end
        end
    end

    // Tone counters
    // A count of 1 or 0 reloads, so period 0 acts as 1
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            tone <= 3'd0;
            for (int i = 0; i < 3; i++) begin
                cnt[i] <= 10'd0;
            end
        end else if (psg_cen) begin
            for (int i = 0; i < 3; i++) begin
                if (cnt[i] <= 10'd1) begin
                    cnt[i]  <= period[i];
                    tone[i] <= ~tone[i];
                end else begin
                    cnt[i]  <= cnt[i] - 10'd1;
                end
            end
        end
    end

    always_comb begin
        level = '0;
        for (int i = 0; i < 3; i++) begin
            if (tone[i])
                level = level + kick_pkg::psg_level_t'((15 - att[i]) * `KICK_VOL_STEP);
        end
    end

endmodule

// ==== design/kick_mixer.sv ====
`timescale 1ns/1ns
`include "kick_consts.svh"

module kick_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  kick_pkg::psg_level_t level0,
    input  kick_pkg::psg_level_t level1,
    output kick_pkg::snd_t       snd,
    output logic                 peak
);

    logic [10:0]    sum;
    logic [19:0]    prod;
    logic [15:0]    scaled;         // Gain applied, still unsigned
    kick_pkg::snd_t snd_next;

    assign sum  = {1'b0, level0} + {1'b0, level1};
    assign prod = 20'(sum) * 20'(`KICK_MIX_GAIN);

    // Drop the four fraction bits of the 4.4 gain
    assign scaled = prod[19:4];

    always_comb begin
        if (scaled > 16'h7fff)
            snd_next = 16'sh7fff;          // Clip at positive full scale
        else
            snd_next = kick_pkg::snd_t'(scaled);
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd  <= '0;
            peak <= 1'b0;
        end else begin
            snd  <= snd_next;
            peak <= snd_next >= 16'(`KICK_PEAK_LEVEL);
        end
    end

endmodule

// ==== design/kick_sound_main.sv ====
`timescale 1ns/1ns

module kick_sound_main (
    input  logic                 clk,
    input  logic                 rst,
    // CPU bus
    input  logic [15:0]          addr,
    input  logic                 rnw,
    input  kick_pkg::kick_byte_t cpu_dout,
    input  logic                 bus_cen,
    input  logic                 psg_cen,
    // Cabinet
    input  logic [1:0]           start_button,
    input  logic [1:0]           coin_input,
    input  logic [5:0]           joystick1,
    input  logic [5:0]           joystick2,
    input  logic                 service,
    input  kick_pkg::kick_byte_t dipsw_a,
    input  kick_pkg::kick_byte_t dipsw_b,
    input  logic [3:0]           dipsw_c,
    input  logic                 dip_pause,
    input  logic                 gfx_irqn,
    output kick_pkg::kick_byte_t cpu_din,
    output logic                 flip,
    output logic [2:0]           pal_sel,
    output kick_pkg::kick_byte_t vpos,
    output logic                 irq_n,
    output kick_pkg::snd_t       snd,
    output logic                 peak
);

    kick_pkg::kick_byte_t ti1_data, ti2_data;
    logic                 ti1_we, ti2_we;
    kick_pkg::psg_level_t ti1_level, ti2_level;

    kick_bus u_bus (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .rnw          (rnw),
        .cpu_dout     (cpu_dout),
        .bus_cen      (bus_cen),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .dip_pause    (dip_pause),
        .gfx_irqn     (gfx_irqn),
        .cpu_din      (cpu_din),
        .flip         (flip),
        .pal_sel      (pal_sel),
        .vpos         (vpos),
        .irq_n        (irq_n),
        .ti1_data     (ti1_data),
        .ti2_data     (ti2_data),
        .ti1_we       (ti1_we),
        .ti2_we       (ti2_we)
    );

    kick_psg u_psg1 (.clk(clk), .rst(rst), .psg_cen(psg_cen), .we(ti1_we),
                     .din(ti1_data), .level(ti1_level));

    kick_psg u_psg2 (.clk(clk), .rst(rst), .psg_cen(psg_cen), .we(ti2_we),
                     .din(ti2_data), .level(ti2_level));

    kick_mixer u_mixer (
        .clk    (clk),
        .rst    (rst),
        .level0 (ti1_level),
        .level1 (ti2_level),
        .snd    (snd),
        .peak   (peak)
    );

endmodule

// ==== bench/kick_chk.sv ====
`timescale 1ns/1ns

module kick_chk (
    input logic clk,
    input logic rst,
    input logic dip_pause,
    input logic gfx_irqn,
    input logic gfx_irqn_l,
    input logic irq_n,
    input logic ti1_we,
    input logic ti2_we
);

    // Interrupt comes out of reset inactive
    a_irq_after_reset: assert property (@(posedge clk) $fell(rst) |-> irq_n)
        else $error("irq_n low in the cycle after reset");

    // Generator strobes last a single cycle
    a_ti1_we_pulse: assert property (@(posedge clk) disable iff (rst) ti1_we |=> !ti1_we)
        else $error("ti1_we high for more than one cycle");

    a_ti2_we_pulse: assert property (@(posedge clk) disable iff (rst) ti2_we |=> !ti2_we)
        else $error("ti2_we high for more than one cycle");

    // irq_n falls only after an edge taken with dip_pause high
    a_irq_from_edge: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> $rose(dip_pause) || $past(dip_pause && gfx_irqn_l && !gfx_irqn))
        else $error("irq_n fell without a gfx_irqn falling edge under dip_pause");

endmodule

bind kick_bus kick_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .dip_pause  (dip_pause),
    .gfx_irqn   (gfx_irqn),
    .gfx_irqn_l (gfx_irqn_l),
    .irq_n      (irq_n),
    .ti1_we     (ti1_we),
    .ti2_we     (ti2_we)
);

// ==== bench/kick_tb.sv ====
`timescale 1ns/1ns
`include "kick_consts.svh"

module kick_tb;

    typedef enum logic [1:0] {op_write, op_read, op_wait} step_op_e;

    localparam int TONE_P = 18;         // Tone period in psg_cen pulses
    localparam int WAIT_LIMIT = 200;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 psg_cen = 1'b0;
    logic [15:0]          addr = 16'h0000;
    logic                 rnw = 1'b1;
    kick_pkg::kick_byte_t cpu_dout = 8'h00;
    logic                 bus_cen = 1'b0;
    logic [1:0]           start_button = 2'b11;
    logic [1:0]           coin_input = 2'b11;
    logic [5:0]           joystick1 = 6'h3f;
    logic [5:0]           joystick2 = 6'h3f;
    logic                 service = 1'b1;
    kick_pkg::kick_byte_t dipsw_a = 8'hff;
    kick_pkg::kick_byte_t dipsw_b = 8'hff;
    logic [3:0]           dipsw_c = 4'hf;
    logic                 dip_pause = 1'b1;
    logic                 gfx_irqn = 1'b1;
    kick_pkg::kick_byte_t cpu_din;
    logic                 flip;
    logic [2:0]           pal_sel;
    kick_pkg::kick_byte_t vpos;
    logic                 irq_n;
    kick_pkg::snd_t       snd;
    logic                 peak;

    logic [31:0]          lfsr = 32'h5b95;

    // Stimulus table, one entry per index
    string                step_name [$];
    step_op_e             step_op   [$];
    logic [15:0]          step_addr [$];
    kick_pkg::kick_byte_t step_data [$];
    logic [15:0]          step_exp  [$];

    kick_sound_main u_kick_sound_main (.*);

    always #20 clk = ~clk;

    always @(posedge clk) psg_cen <= rst ? 1'b0 : ~psg_cen;   // Every second cycle

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Up/down and left/right swap places, spare bits read high
    function automatic kick_pkg::kick_byte_t joystick_port(input logic [5:0] joy);
        kick_pkg::kick_byte_t b;
        b      = 8'hff;
        b[0]   = joy[1];
        b[1]   = joy[0];
        b[2]   = joy[3];
        b[3]   = joy[2];
        b[5:4] = joy[5:4];
        return b;
    endfunction

    function automatic kick_pkg::kick_byte_t system_port(input logic [1:0] start,
                                                         input logic svc, input logic [1:0] coin);
        kick_pkg::kick_byte_t b;
        b      = 8'hff;
        b[1:0] = coin;
        b[2]   = svc;
        b[4:3] = start;
        return b;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input kick_pkg::kick_byte_t exp,
                              input kick_pkg::kick_byte_t act);
        if (act !== exp)
            stop_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_snd(input string name, input kick_pkg::snd_t exp,
                             input kick_pkg::snd_t act);
        if (act !== exp)
            stop_with_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_with_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    // One bus strobe, returns once the registered outputs have settled
    task automatic bus_cycle(input logic [15:0] a, input logic read,
                             input kick_pkg::kick_byte_t d);
        @(posedge clk);
        addr     <= a;
        rnw      <= read;
        cpu_dout <= d;
        bus_cen  <= 1'b1;
        @(posedge clk);
        bus_cen  <= 1'b0;
        rnw      <= 1'b1;
        @(negedge clk);
    endtask

    task automatic wait_snd(input string name, input kick_pkg::snd_t level, input int limit,
                            output int cycles);
        cycles = 0;
        while (snd !== level) begin
            if (cycles == limit)
                stop_with_failure($sformatf("Timeout in %s: snd never reached %0d", name, level));
            else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic wait_irq_low(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (irq_n !== 1'b0) begin
            if (cycles == limit)
                stop_with_failure($sformatf("Timeout in %s: irq_n never went low", name));
            else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic add_step(input string name, input step_op_e op, input logic [15:0] a,
                            input kick_pkg::kick_byte_t d, input logic [15:0] exp);
        step_name.push_back(name);
        step_op.push_back(op);
        step_addr.push_back(a);
        step_data.push_back(d);
        step_exp.push_back(exp);
    endtask

    // Data latch first, then the strobe that hands it to the generator
    task automatic add_psg_write(input string name, input int gen, input kick_pkg::kick_byte_t b);
        add_step(name, op_write, gen == 1 ? `KICK_TIDATA1_BASE : `KICK_TIDATA2_BASE, b, 16'h0);
        add_step(name, op_write, gen == 1 ? `KICK_TI1_ADDR : `KICK_TI2_ADDR, 8'h00, 16'h0);
    endtask

    task automatic run_table();
        int cycles;
        for (int i = 0; i < step_name.size(); i++) begin
            case (step_op[i])
                op_write: bus_cycle(step_addr[i], 1'b0, step_data[i]);
                op_read: begin
                    bus_cycle(step_addr[i], 1'b1, 8'h00);
                    check_byte(step_name[i], step_exp[i][7:0], cpu_din);
                end
                default: wait_snd(step_name[i], kick_pkg::snd_t'(step_exp[i]), WAIT_LIMIT, cycles);
            endcase
        end
        step_name.delete();
        step_op.delete();
        step_addr.delete();
        step_data.delete();
        step_exp.delete();
    endtask

    initial begin
        logic [31:0]          r;
        int                   gap;
        kick_pkg::kick_byte_t vscroll;
        apply_reset();
        check_bit("reset flip", 1'b0, flip);
        check_byte("reset pal_sel", 8'h00, {5'b0, pal_sel});
        check_byte("reset vpos", 8'h00, vpos);
        check_snd("reset snd", 16'sd0, snd);
        check_bit("reset peak", 1'b0, peak);
        check_bit("reset irq_n", 1'b1, irq_n);

        draw_bits(17, r);
        @(posedge clk);
        start_button <= r[1:0];
        coin_input   <= r[3:2];
        joystick1    <= r[9:4];
        joystick2    <= r[15:10];
        service      <= r[16];
        draw_bits(20, r);
        dipsw_a      <= r[7:0];
        dipsw_b      <= r[15:8];
        dipsw_c      <= r[19:16];
        @(negedge clk);

        add_step("in port 0", op_read, `KICK_IN_BASE, 8'h00, {8'h00, 4'hf, dipsw_c});
        add_step("in port 1", op_read, `KICK_IN_BASE + 16'd1, 8'h00,
                 {8'h00, joystick_port(joystick2)});
        add_step("in port 2", op_read, `KICK_IN_BASE + 16'd2, 8'h00,
                 {8'h00, joystick_port(joystick1)});
        add_step("in port 3", op_read, `KICK_IN_BASE + 16'd3, 8'h00,
                 {8'h00, system_port(start_button, service, coin_input)});
        add_step("dip a", op_read, `KICK_DIP_ADDR, 8'h00, {8'h00, dipsw_a});
        add_step("dip b", op_read, `KICK_DIP_ADDR + 16'd1, 8'h00, {8'h00, dipsw_b});
        add_step("unmapped rom", op_read, 16'h4000, 8'h00, 16'h00ff);
        add_step("write-only iow", op_read, `KICK_IOW_ADDR, 8'h00, 16'h00ff);
        add_psg_write("tone0 period low", 1, {4'h8, TONE_P[3:0]});
        add_psg_write("tone0 period high", 1, {2'b00, TONE_P[9:4]});
        add_psg_write("tone0 att 0", 1, 8'h90);
        add_step("one tone on", op_wait, 16'h0, 8'h00, 16'd960);
        run_table();
        check_bit("one tone peak", 1'b0, peak);

        // Skip the partial first half-period, then time two edges
        wait_snd("tone low", 16'sd0, WAIT_LIMIT, gap);
        wait_snd("tone high", 16'sd960, WAIT_LIMIT, gap);
        wait_snd("tone fall", 16'sd0, WAIT_LIMIT, gap);
        check_count("tone high time", 2 * TONE_P, gap);
        wait_snd("tone rise", 16'sd960, WAIT_LIMIT, gap);
        check_count("tone low time", 2 * TONE_P, gap);

        bus_cycle(`KICK_IOW_ADDR, 1'b0, 8'h01);
        check_bit("flip set", 1'b1, flip);
        bus_cycle(`KICK_COLOR_BASE, 1'b0, 8'hfd);
        check_byte("pal_sel", 8'h05, {5'b0, pal_sel});
        draw_bits(8, r);
        vscroll = r[7:0];
        bus_cycle(`KICK_VSCR_BASE, 1'b0, vscroll);
        check_byte("vpos", vscroll, vpos);
        bus_cycle(`KICK_IOW_ADDR, 1'b0, 8'h00);
        check_bit("flip clear", 1'b0, flip);

        bus_cycle(`KICK_IOW_ADDR, 1'b0, 8'h04);     // Interrupt enable
        check_bit("irq idle", 1'b1, irq_n);
        @(posedge clk);
        gfx_irqn <= 1'b0;
        wait_irq_low("irq taken", 4);
        @(posedge clk);
        gfx_irqn <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_bit("irq held", 1'b0, irq_n);
        end
        bus_cycle(`KICK_IOW_ADDR, 1'b0, 8'h00);
        check_bit("irq cleared", 1'b1, irq_n);
        bus_cycle(`KICK_IOW_ADDR, 1'b0, 8'h04);
        check_bit("irq stays clear", 1'b1, irq_n);
        @(posedge clk);
        dip_pause <= 1'b0;                          // Paused board ignores the edge
        gfx_irqn  <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_bit("irq paused", 1'b1, irq_n);
        end
        @(posedge clk);
        dip_pause <= 1'b1;
        gfx_irqn  <= 1'b1;
        @(negedge clk);
        check_bit("irq not latched", 1'b1, irq_n);

        // Fresh reset keeps all six tones in step
        apply_reset();
        for (int g = 1; g <= 2; g++) begin
            for (int ch = 0; ch < 3; ch++) begin
                add_psg_write("burst period low", g, {1'b1, 3'(2 * ch), 4'h0});
                add_psg_write("burst period high", g, 8'h00);
                add_psg_write("burst att 0", g, {1'b1, 3'(2 * ch + 1), 4'h0});
            end
        end
        add_step("all tones on", op_wait, 16'h0, 8'h00, 16'd5760);
        run_table();
        check_bit("peak at full level", 1'b1, peak);
        for (int g = 1; g <= 2; g++) begin
            for (int ch = 0; ch < 3; ch++)
                add_psg_write("silence", g, {1'b1, 3'(2 * ch + 1), 4'hf});
        end
        add_step("all tones off", op_wait, 16'h0, 8'h00, 16'd0);
        run_table();
        repeat (4) @(negedge clk);
        repeat (8) begin
            @(negedge clk);
            check_snd("silent snd", 16'sd0, snd);
            check_bit("silent peak", 1'b0, peak);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/kick_pkg.sv
design/kick_bus.sv
design/kick_psg.sv
design/kick_mixer.sv
design/kick_sound_main.sv
bench/kick_chk.sv
bench/kick_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kick_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FLIST)) design/kick_consts.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
